//--- sim.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_dest_decode.sv
rtl/wb_redirect.sv
rtl/wb_fault_merge.sv
rtl/wb_stage.sv
testbench/wb_clk_gen.sv
testbench/wb_asserts.sv
testbench/wb_checker.sv
testbench/wb_tb.sv

//--- Makefile
SRCS := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

obj_dir/Vwb_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module wb_tb -f sim.f

run: obj_dir/Vwb_tb
	@out="$$(./obj_dir/Vwb_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- testbench/wb_tb.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_tb;
    import wb_pkg::*;

    typedef struct packed {
        wb_slot_t [`WB_SLOTS-1:0] slots;
        wb_uop_t     uop;
        wb_branch_t  br;
        logic        valid_in;
        logic [31:0] eip_in;
        logic [31:0] latched_eip_in;
        logic [15:0] cs_in;
        logic [19:0] cs_limit;
        logic        ie_in;
        logic [3:0]  ie_type_in;
        logic        idt_orig;
        logic        idt_busy;
        logic        interrupt_in;
        logic        wbaq_full;
        logic        exp_vo;
        logic        chk;
    } row_t;

    logic clk, arst_n;
    wb_slot_t [`WB_SLOTS-1:0] slots;
    wb_uop_t uop;
    wb_branch_t br;
    logic valid_in, ie_in, idt_orig, idt_busy, interrupt_in, wbaq_full, tbl_chk, tbl_exp_vo;
    logic [31:0] eip_in, latched_eip_in;
    logic [15:0] cs_in;
    logic [19:0] cs_limit;
    logic [3:0] ie_type_in;
    logic valid_out, stall, mem_ld, br_valid, resteer, final_wb, is_iretd, halted;
    logic [63:0] res1, res2, res3, res4, mem_data;
    logic [1:0] ressize, mem_size;
    logic [31:0] mem_addr, new_eip, new_fip_e, new_fip_o, eip_hist1, eip_hist2;
    logic [7:0] bp_alias_out;
    logic [3*`WB_SLOTS-1:0] reg_addr;
    wb_strobe_t strobes;
    wb_event_t wb_event;
    int errors;
    int total;
    int seed;
    logic ready;
    row_t rows[$];
    row_t r;

    wb_clk_gen u_clk (.clk(clk), .arst_n(arst_n));
    wb_stage dut (.*);
    wb_checker u_check (.*);

    // kind is {is_reg, is_seg, is_mem, wb}
    function automatic wb_slot_t mk_slot(input logic [63:0] d, input logic [31:0] dest,
                                         input logic [3:0] kind);
        wb_slot_t s;
        s = {d, dest, kind};
        return s;
    endfunction

    function automatic row_t base_row();
        row_t b;
        b = '0;
        b.valid_in       = 1'b1;
        b.cs_limit       = 20'hFFFFF;
        b.eip_in         = 32'h0000_4000;
        b.latched_eip_in = 32'hE000_0000 + 32'(rows.size());
        b.br.fip_p1      = 32'h0000_0010;
        b.exp_vo         = 1'b1;
        b.chk            = 1'b1;
        return b;
    endfunction

    task automatic add_random_row();
        logic [31:0] x;
        row_t b;
        b = base_row();
        b.chk = 1'b0;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            x = $random(seed);
            b.slots[i] = mk_slot({x, 32'($random(seed))}, 32'($random(seed)), x[3:0]);
        end
        x = $random(seed);
        b.uop          = {x[4], 1'b0, x[13:5]};  // never a halt
        b.uop.mem_size_ovr = x[11] ? 4'(1 << x[13:12]) : 4'h0;
        b.br           = {x[16:14], 32'($random(seed)), 32'($random(seed)), x[31:24]};
        b.eip_in       = $random(seed);
        b.cs_in        = x[31:16];
        b.cs_limit     = 20'($random(seed));
        x = $random(seed);
        b.ie_in        = &x[2:0];
        b.ie_type_in   = x[7:4];
        b.idt_orig     = &x[9:8];
        b.idt_busy     = x[10];
        b.interrupt_in = &x[13:11];
        b.wbaq_full    = x[14];
        b.valid_in     = |x[16:15];
        rows.push_back(b);
    endtask

    task automatic build_table();
        r = base_row();
        r.slots[0] = mk_slot(64'h1111, 32'd3, 4'b1001);
        rows.push_back(r);
        r = base_row();
        r.slots[0] = mk_slot(64'h2222, 32'd5, 4'b1001);
        r.slots[1] = mk_slot(64'h3333, 32'd2, 4'b0101);
        r.slots[2] = mk_slot(64'hAAAA_5555, 32'h8000_0040, 4'b0011);
        r.slots[3] = mk_slot(64'hBBBB, 32'h8000_0080, 4'b0011);
        rows.push_back(r);
        for (int k = 0; k < 4; k++) begin  // each size override
            r = base_row();
            r.slots[1] = mk_slot(64'h44, 32'h100, 4'b0011);
            r.uop.mem_size_ovr = 4'(1 << k);
            r.uop.op_size = 2'd1;
            rows.push_back(r);
        end
        r = base_row();
        r.slots[3] = mk_slot(64'h55, 32'h200, 4'b0011);
        r.uop.op_size = 2'd2;
        rows.push_back(r);
        r = base_row();  // back-pressure
        r.slots[0] = mk_slot(64'h66, 32'h300, 4'b0011);
        r.slots[1] = mk_slot(64'h67, 32'd6, 4'b1001);
        r.wbaq_full = 1'b1;
        r.exp_vo = 1'b0;
        rows.push_back(r);
        r = base_row();
        r.slots[0] = mk_slot(64'h77, 32'd4, 4'b1001);
        r.wbaq_full = 1'b1;
        rows.push_back(r);
        r = base_row();  // far transfer writing CS
        r.slots[0] = mk_slot(64'h0000_0023_0040_1000, 32'd0, 4'b0000);
        r.slots[1] = mk_slot(64'h0, 32'd1, 4'b0000);
        r.uop.far_load = 1'b1;
        r.br.valid = 1'b1;
        r.br.taken = 1'b1;
        r.br.correct = 1'b1;
        r.br.fip = 32'h0040_1000;
        r.br.fip_p1 = 32'h0040_1010;
        r.cs_in = 16'h0040;  // target line stays below the limit
        rows.push_back(r);
        r = base_row();  // mispredict, even line
        r.br = {3'b110, 32'h0001_2340, 32'h0001_2350, 8'h5A};
        rows.push_back(r);
        r = base_row();  // odd line
        r.br = {3'b111, 32'h0001_2354, 32'h0001_2364, 8'h11};
        rows.push_back(r);
        r = base_row();
        r.br = {3'b101, 32'h0001_2354, 32'h0001_2364, 8'h22};
        r.eip_in = 32'h5555;
        rows.push_back(r);
        r = base_row();  // line end at the limit
        r.br = {3'b111, 32'h0001_2340, 32'h0001_2350, 8'h0};
        r.cs_limit = 20'h1234F;
        rows.push_back(r);
        r = base_row();
        r.br = {3'b111, 32'h0001_2340, 32'h0001_2350, 8'h0};
        r.cs_limit = 20'h12350;
        rows.push_back(r);
        r = base_row();
        r.ie_in = 1'b1;
        r.ie_type_in = 4'b0010;
        r.interrupt_in = 1'b1;
        r.exp_vo = 1'b0;
        rows.push_back(r);
        r = base_row();
        r.interrupt_in = 1'b1;
        rows.push_back(r);
        r = base_row();
        r.ie_in = 1'b1;
        r.ie_type_in = 4'b0001;
        r.idt_busy = 1'b1;
        r.exp_vo = 1'b0;
        rows.push_back(r);
        r = base_row();
        r.ie_in = 1'b1;
        r.idt_orig = 1'b1;
        r.uop.is_jmp = 1'b1;
        rows.push_back(r);
        r = base_row();
        r.valid_in = 1'b0;
        r.exp_vo = 1'b0;
        r.slots[0] = mk_slot(64'h88, 32'd2, 4'b1001);
        rows.push_back(r);
        for (int n = 0; n < 200; n++) begin
            add_random_row();
        end
        r = base_row();
        r.uop.is_halt = 1'b1;
        rows.push_back(r);
        r = base_row();  // halted stalls
        r.exp_vo = 1'b0;
        rows.push_back(r);
        r = base_row();
        r.exp_vo = 1'b0;
        rows.push_back(r);
    endtask

    initial begin
        slots = '0;
        uop = '0;
        br = '0;
        valid_in = 1'b0;
        eip_in = '0;
        latched_eip_in = '0;
        cs_in = '0;
        cs_limit = '0;
        ie_in = 1'b0;
        ie_type_in = '0;
        idt_orig = 1'b0;
        idt_busy = 1'b0;
        interrupt_in = 1'b0;
        wbaq_full = 1'b0;
        tbl_chk = 1'b0;
        tbl_exp_vo = 1'b0;
        ready = 1'b0;
        seed = 35609;
        build_table();
        ready = 1'b1;
        wait (arst_n === 1'b1);
        foreach (rows[i]) begin
            @(posedge clk);
            slots <= rows[i].slots;
            uop <= rows[i].uop;
            br <= rows[i].br;
            valid_in <= rows[i].valid_in;
            eip_in <= rows[i].eip_in;
            latched_eip_in <= rows[i].latched_eip_in;
            cs_in <= rows[i].cs_in;
            cs_limit <= rows[i].cs_limit;
            ie_in <= rows[i].ie_in;
            ie_type_in <= rows[i].ie_type_in;
            idt_orig <= rows[i].idt_orig;
            idt_busy <= rows[i].idt_busy;
            interrupt_in <= rows[i].interrupt_in;
            wbaq_full <= rows[i].wbaq_full;
            tbl_chk <= rows[i].chk;
            tbl_exp_vo <= rows[i].exp_vo;
        end
        @(posedge clk);
        valid_in <= 1'b0;
        tbl_chk  <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        total = errors + dut.u_asserts.fails;
        $display("checker errors %0d, assertion failures %0d", errors, dut.u_asserts.fails);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (ready === 1'b1);
        #((rows.size() + 20) * 8 * 2);
        $display("timeout, the stimulus did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- testbench/wb_checker.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_checker (
    input  logic                             clk,
    input  logic                             arst_n,
    input  wb_pkg::wb_slot_t [`WB_SLOTS-1:0] slots,
    input  wb_pkg::wb_uop_t                  uop,
    input  wb_pkg::wb_branch_t               br,
    input  logic                             valid_in,
    input  logic [31:0]                      eip_in,
    input  logic [31:0]                      latched_eip_in,
    input  logic [15:0]                      cs_in,
    input  logic [19:0]                      cs_limit,
    input  logic                             ie_in,
    input  logic [3:0]                       ie_type_in,
    input  logic                             idt_orig,
    input  logic                             idt_busy,
    input  logic                             interrupt_in,
    input  logic                             wbaq_full,
    input  logic                             tbl_chk,
    input  logic                             tbl_exp_vo,
    input  logic                             valid_out,
    input  logic                             stall,
    input  logic [63:0]                      res1,
    input  logic [63:0]                      res2,
    input  logic [63:0]                      res3,
    input  logic [63:0]                      res4,
    input  logic [1:0]                       ressize,
    input  logic [63:0]                      mem_data,
    input  logic [31:0]                      mem_addr,
    input  logic [1:0]                       mem_size,
    input  logic                             mem_ld,
    input  wb_pkg::wb_strobe_t               strobes,
    input  logic [3*`WB_SLOTS-1:0]           reg_addr,
    input  logic [31:0]                      new_eip,
    input  logic [31:0]                      new_fip_e,
    input  logic [31:0]                      new_fip_o,
    input  logic                             br_valid,
    input  logic                             resteer,
    input  logic [7:0]                       bp_alias_out,
    input  wb_pkg::wb_event_t                wb_event,
    input  logic                             final_wb,
    input  logic                             is_iretd,
    input  logic                             halted,
    input  logic [31:0]                      eip_hist1,
    input  logic [31:0]                      eip_hist2,
    output int                               errors
);
    import wb_pkg::*;

    logic        e_stall, e_vo, e_req, e_fault, e_val, e_csw, e_rst, e_found, g;
    logic [3:0]  e_type;
    wb_strobe_t  e_stb;
    logic [63:0] e_mdata, e_res1, e_res2;
    logic [31:0] e_maddr, e_eip, e_fe, e_fo, lend, csmax;
    logic [15:0] tcs;
    logic [1:0]  e_msize;
    logic [3*`WB_SLOTS-1:0] e_raddr;
    logic        halted_m;
    logic [31:0] h1_m, h2_m;

    always_comb begin
        e_req = 1'b0;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            e_req = e_req | (slots[i].is_mem & slots[i].wb);
        end
        e_req   = e_req & valid_in;
        e_stall = (wbaq_full & e_req) | halted_m;
        e_vo    = valid_in & ((~e_stall & ~ie_in) | idt_orig);
        e_stb   = '0;
        e_mdata = '0;
        e_maddr = '0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            e_stb.reg_ld[i]    = slots[i].is_reg & slots[i].wb & e_vo;
            e_stb.seg_ld[i]    = slots[i].is_seg & slots[i].wb & e_vo;
            e_stb.mem_sel[i]   = slots[i].is_mem & slots[i].wb & e_vo;
            e_raddr[3*i +: 3]  = slots[i].dest.regs.idx;
            if (e_stb.mem_sel[i]) begin
                e_mdata = slots[i].data;
                e_maddr = slots[i].dest.mem_addr;
            end
        end
        e_stb.seg_ld[1] = e_stb.seg_ld[1] | (uop.far_load & e_vo);
        e_found = 1'b0;
        e_msize = uop.far_load ? 2'd3 : uop.op_size;
        for (int k = 0; k < 4; k++) begin
            if (uop.mem_size_ovr[k] && !e_found) begin
                e_msize = 2'(k);
                e_found = 1'b1;
            end
        end
        lend    = {br.fip[31:4], 4'hF};
        csmax   = {cs_in, 16'h0} + {12'h0, cs_limit};
        e_fault = valid_in & br.valid & br.taken & (lend >= csmax);
        g       = valid_in & ~idt_busy;
        e_type[0] = (g & ie_type_in[0]) | e_fault;
        e_type[1] = g & ie_type_in[1];
        e_type[2] = 1'b0;
        e_type[3] = interrupt_in & ~e_type[0] & ~e_type[1];
        e_val     = (ie_in & g) | interrupt_in | e_fault;
        e_res1 = uop.far_load ? {32'h0, slots[0].data[31:0]} : slots[0].data;
        e_res2 = uop.far_load ? {48'h0, slots[0].data[47:32]} : slots[1].data;
        e_csw  = 1'b0;
        tcs    = cs_in;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (e_stb.seg_ld[i] && slots[i].dest.regs.idx == 3'd1) begin
                e_csw = 1'b1;
                tcs   = (i == 0) ? e_res1[15:0] : (i == 1) ? e_res2[15:0] : slots[i].data[15:0];
            end
        end
        e_eip = br.taken ? (uop.far_load ? slots[0].data[31:0] : br.fip) : eip_in;
        e_fe  = br.fip[4] ? {br.fip_p1[31:4], 4'h0} : {br.fip[31:4], 4'h0};
        e_fo  = br.fip[4] ? {br.fip[31:4], 4'h0} : {br.fip_p1[31:4], 4'h0};
        if (e_csw) begin
            e_eip[31:16] = e_eip[31:16] + tcs;
            e_fe[31:16]  = e_fe[31:16] + tcs;
            e_fo[31:16]  = e_fo[31:16] + tcs;
        end
        if (e_val) begin
            e_eip = '0;
            e_fe  = '0;
            e_fo  = 32'd16;
        end
        e_rst = valid_in & br.valid & e_vo & ~e_val & (~br.correct | e_csw);
    end

    // reference copy of the sequential state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted_m <= 1'b0;
            h1_m     <= '0;
            h2_m     <= '0;
        end else if (e_vo) begin
            if (uop.is_halt) begin
                halted_m <= 1'b1;
            end
            h1_m <= latched_eip_in;
            h2_m <= h1_m;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    initial errors = 0;

    always @(negedge clk) begin
        if (arst_n) begin
            if (tbl_chk) begin
                check("table valid_out", 64'(valid_out), 64'(tbl_exp_vo));
            end
            check("valid_out", 64'(valid_out), 64'(e_vo));
            check("stall", 64'(stall), 64'(e_stall));
            check("strobes", 64'(strobes), 64'(e_stb));
            check("reg_addr", 64'(reg_addr), 64'(e_raddr));
            check("mem_ld", 64'(mem_ld), 64'(|e_stb.mem_sel));
            check("mem_data", mem_data, e_mdata);
            check("mem_addr", 64'(mem_addr), 64'(e_maddr));
            check("mem_size", 64'(mem_size), 64'(e_msize));
            check("res1", res1, e_res1);
            check("res2", res2, e_res2);
            check("res3", res3, slots[2].data);  // passed through
            check("res4", res4, slots[3].data);
            check("ressize", 64'(ressize), 64'(uop.op_size));
            check("new_eip", 64'(new_eip), 64'(e_eip));
            check("new_fip_e", 64'(new_fip_e), 64'(e_fe));
            check("new_fip_o", 64'(new_fip_o), 64'(e_fo));
            check("br_valid", 64'(br_valid), 64'(br.valid & e_vo));
            check("resteer", 64'(resteer), 64'(e_rst));
            check("bp_alias_out", 64'(bp_alias_out), 64'(br.bp_alias));
            check("event", 64'(wb_event), 64'({e_val, e_type}));
            check("final_wb", 64'(final_wb),
                  64'(valid_in & idt_orig & (uop.is_jmp | uop.is_ret_far)));
            check("is_iretd", 64'(is_iretd), 64'(uop.is_iretd));
            check("halted", 64'(halted), 64'(halted_m));
            check("eip_hist1", 64'(eip_hist1), 64'(h1_m));
            check("eip_hist2", 64'(eip_hist2), 64'(h2_m));
        end
    end

endmodule

//--- testbench/wb_asserts.sv
`timescale 1ns/1ps

module wb_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               valid_out,
    input wb_pkg::wb_strobe_t strobes,
    input logic               halted,
    input logic               resteer,
    input wb_pkg::wb_event_t  wb_event
);

    int fails = 0;

    a_strobe_gated: assert property (@(posedge clk) disable iff (!arst_n)
        !valid_out |-> strobes == '0)
        else begin fails++; $error("strobe active while valid_out is low"); end

    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
        else begin fails++; $error("halted fell without a reset"); end

    a_resteer_event: assert property (@(posedge clk) disable iff (!arst_n)
        !(resteer && wb_event.val))
        else begin fails++; $error("resteer raised together with an event"); end

endmodule

bind wb_stage wb_asserts u_asserts (.*);

//--- testbench/wb_clk_gen.sv
`timescale 1ns/1ps

module wb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- rtl/wb_stage.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_stage (
    input  logic                             clk,
    input  logic                             arst_n,
    input  wb_pkg::wb_slot_t [`WB_SLOTS-1:0] slots,
    input  wb_pkg::wb_uop_t                  uop,
    input  wb_pkg::wb_branch_t               br,
    input  logic                             valid_in,
    input  logic [31:0]                      eip_in,
    input  logic [31:0]                      latched_eip_in,
    input  logic [15:0]                      cs_in,
    input  logic [19:0]                      cs_limit,
    input  logic                             ie_in,
    input  logic [3:0]                       ie_type_in,
    input  logic                             idt_orig,
    input  logic                             idt_busy,
    input  logic                             interrupt_in,
    input  logic                             wbaq_full,
    output logic                             valid_out,
    output logic                             stall,
    output logic [63:0]                      res1,
    output logic [63:0]                      res2,
    output logic [63:0]                      res3,
    output logic [63:0]                      res4,
    output logic [1:0]                       ressize,
    output logic [63:0]                      mem_data,
    output logic [31:0]                      mem_addr,
    output logic [1:0]                       mem_size,
    output logic                             mem_ld,
    output wb_pkg::wb_strobe_t               strobes,
    output logic [3*`WB_SLOTS-1:0]           reg_addr,
    output logic [31:0]                      new_eip,
    output logic [31:0]                      new_fip_e,
    output logic [31:0]                      new_fip_o,
    output logic                             br_valid,
    output logic                             resteer,
    output logic [7:0]                       bp_alias_out,
    output wb_pkg::wb_event_t                wb_event,
    output logic                             final_wb,
    output logic                             is_iretd,
    output logic                             halted,
    output logic [31:0]                      eip_hist1,
    output logic [31:0]                      eip_hist2
);

    logic [`WB_SLOTS-1:0] mem_req_slot;
    logic                 mem_req;

    // raw request, not qualified by valid_out, so stall has no loop
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            mem_req_slot[i] = slots[i].is_mem & slots[i].wb;
        end
    end

    assign mem_req   = valid_in & |mem_req_slot;
    assign stall     = (wbaq_full & mem_req) | halted;
    assign valid_out = (valid_in & ~stall & ~ie_in) | (valid_in & idt_orig);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted    <= 1'b0;
            eip_hist1 <= '0;
            eip_hist2 <= '0;
        end else begin
            if (valid_out && uop.is_halt) begin
                halted <= 1'b1;         // sticky until reset
            end
            if (valid_out) begin
                eip_hist1 <= latched_eip_in;
                eip_hist2 <= eip_hist1;
            end
        end
    end

    assign res3         = slots[2].data;
    assign res4         = slots[3].data;
    assign ressize      = uop.op_size;
    assign bp_alias_out = br.bp_alias;
    assign is_iretd     = uop.is_iretd;
    assign final_wb     = valid_in & idt_orig & (uop.is_jmp | uop.is_ret_far);

    wb_dest_decode u_decode (
        .slots     (slots),
        .uop       (uop),
        .valid_out (valid_out),
        .strobes   (strobes),
        .mem_ld    (mem_ld),
        .mem_data  (mem_data),
        .mem_addr  (mem_addr),
        .mem_size  (mem_size),
        .reg_addr  (reg_addr)
    );

    wb_redirect u_redirect (
        .slots     (slots),
        .uop       (uop),
        .br        (br),
        .strobes   (strobes),
        .eip_in    (eip_in),
        .cs_in     (cs_in),
        .wb_event  (wb_event),
        .valid_out (valid_out),
        .valid_in  (valid_in),
        .res1      (res1),
        .res2      (res2),
        .new_eip   (new_eip),
        .new_fip_e (new_fip_e),
        .new_fip_o (new_fip_o),
        .resteer   (resteer),
        .br_valid  (br_valid)
    );

    wb_fault_merge u_fault (
        .br           (br),
        .valid_in     (valid_in),
        .cs_in        (cs_in),
        .cs_limit     (cs_limit),
        .ie_in        (ie_in),
        .ie_type_in   (ie_type_in),
        .idt_busy     (idt_busy),
        .interrupt_in (interrupt_in),
        .wb_event     (wb_event)
    );

endmodule

//--- rtl/wb_fault_merge.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_fault_merge (
    input  wb_pkg::wb_branch_t br,
    input  logic               valid_in,
    input  logic [15:0]        cs_in,
    input  logic [19:0]        cs_limit,
    input  logic               ie_in,
    input  logic [3:0]         ie_type_in,
    input  logic               idt_busy,
    input  logic               interrupt_in,
    output wb_pkg::wb_event_t  wb_event
);

    logic [31:0] cs_max;
    logic [31:0] line_end;
    logic        seg_fault;
    logic        ie_gate;
    logic        type_seg;
    logic        type_page;

    assign cs_max   = {cs_in, 16'h0} + {12'h0, cs_limit};
    assign line_end = {br.fip[31:4], 4'hF};  // last byte of the target line

    // only a taken branch of a live instruction can fault
    assign seg_fault = valid_in & br.valid & br.taken & (line_end >= cs_max);

    // masked while the IDT is already servicing an event
    assign ie_gate = valid_in & ~idt_busy;

    assign type_seg  = (ie_gate & ie_type_in[`WB_IE_SEG]) | seg_fault;
    assign type_page = ie_gate & ie_type_in[`WB_IE_PAGE];

    always_comb begin
        wb_event.ie_type              = '0;
        wb_event.ie_type[`WB_IE_SEG]  = type_seg;
        wb_event.ie_type[`WB_IE_PAGE] = type_page;
        wb_event.ie_type[`WB_IE_INTR] = interrupt_in & ~type_seg & ~type_page; // faults first
        wb_event.val                  = (ie_in & ie_gate) | interrupt_in | seg_fault;
    end

endmodule

//--- rtl/wb_redirect.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_redirect (
    input  wb_pkg::wb_slot_t [`WB_SLOTS-1:0] slots,
    input  wb_pkg::wb_uop_t                  uop,
    input  wb_pkg::wb_branch_t               br,
    input  wb_pkg::wb_strobe_t               strobes,
    input  logic [31:0]                      eip_in,
    input  logic [15:0]                      cs_in,
    input  wb_pkg::wb_event_t                wb_event,
    input  logic                             valid_out,
    input  logic                             valid_in,
    output logic [63:0]                      res1,
    output logic [63:0]                      res2,
    output logic [31:0]                      new_eip,
    output logic [31:0]                      new_fip_e,
    output logic [31:0]                      new_fip_o,
    output logic                             resteer,
    output logic                             br_valid
);

    logic [63:0] res_v [`WB_SLOTS];
    logic        cs_write;
    logic [15:0] true_cs;
    logic [31:0] target;
    logic [31:0] eip_sel;
    logic [31:0] fip_e_line;
    logic [31:0] fip_o_line;

    // segment base lives in the upper half of the linear address
    function automatic logic [31:0] cs_adj(input logic [31:0] a, input logic [15:0] cs,
                                           input logic en);
        logic [31:0] r;
        r = a;
        if (en) begin
            r[31:16] = a[31:16] + cs;
        end
        return r;
    endfunction

    // slot 0 holds {selector, offset} on a far transfer
    assign res1 = uop.far_load ? {32'h0, slots[0].data[31:0]} : slots[0].data;
    assign res2 = uop.far_load ? {48'h0, slots[0].data[47:32]} : slots[1].data;

    always_comb begin
        res_v[0] = res1;
        res_v[1] = res2;
        for (int i = 2; i < `WB_SLOTS; i++) begin
            res_v[i] = slots[i].data;
        end
    end

    // segment index 1 is CS
    always_comb begin
        cs_write = 1'b0;
        true_cs  = cs_in;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (strobes.seg_ld[i] && slots[i].dest.regs.idx == 3'd1) begin
                cs_write = 1'b1;
                true_cs  = res_v[i][15:0];
            end
        end
    end

    assign target  = uop.far_load ? slots[0].data[31:0] : br.fip;
    assign eip_sel = br.taken ? target : eip_in;

    assign fip_e_line = br.fip[4] ? {br.fip_p1[31:4], 4'h0} : {br.fip[31:4], 4'h0};
    assign fip_o_line = br.fip[4] ? {br.fip[31:4], 4'h0} : {br.fip_p1[31:4], 4'h0};

    always_comb begin
        if (wb_event.val) begin
            new_eip   = '0;     // handler entry comes from the IDT
            new_fip_e = '0;
            new_fip_o = 32'(`WB_FIP_ODD_RESET);
        end else begin
            new_eip   = cs_adj(eip_sel, true_cs, cs_write);
            new_fip_e = cs_adj(fip_e_line, true_cs, cs_write);
            new_fip_o = cs_adj(fip_o_line, true_cs, cs_write);
        end
    end

    assign br_valid = br.valid & valid_out;
    assign resteer  = valid_in & br_valid & ~wb_event.val & (~br.correct | cs_write);

endmodule

//--- rtl/wb_dest_decode.sv
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_dest_decode (
    input  wb_pkg::wb_slot_t [`WB_SLOTS-1:0] slots,
    input  wb_pkg::wb_uop_t                  uop,
    input  logic                             valid_out,
    output wb_pkg::wb_strobe_t               strobes,
    output logic                             mem_ld,
    output logic [63:0]                      mem_data,
    output logic [31:0]                      mem_addr,
    output logic [1:0]                       mem_size,
    output logic [3*`WB_SLOTS-1:0]           reg_addr
);

    // per-slot load strobes, all qualified by valid_out
    always_comb begin
        strobes  = '0;
        reg_addr = '0;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            strobes.reg_ld[i]  = slots[i].is_reg & slots[i].wb & valid_out;
            strobes.seg_ld[i]  = slots[i].is_seg & slots[i].wb & valid_out;
            strobes.mem_sel[i] = slots[i].is_mem & slots[i].wb & valid_out;
            reg_addr[3*i +: 3] = slots[i].dest.regs.idx;
        end
        // CS selector of a far transfer goes out on slot 1
        strobes.seg_ld[1] = strobes.seg_ld[1] | (uop.far_load & valid_out);
    end

    assign mem_ld = |strobes.mem_sel;

    // lowest selected slot wins
    always_comb begin
        mem_data = '0;
        mem_addr = '0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (strobes.mem_sel[i]) begin
                mem_data = slots[i].data;
                mem_addr = slots[i].dest.mem_addr;
            end
        end
    end

    always_comb begin
        if (|uop.mem_size_ovr) begin
            mem_size = 2'd0;
            for (int k = 3; k >= 0; k--) begin
                if (uop.mem_size_ovr[k]) begin
                    mem_size = 2'(k);
                end
            end
        end else if (uop.far_load) begin
            mem_size = 2'd3;    // offset plus selector
        end else begin
            mem_size = uop.op_size;
        end
    end

endmodule

//--- rtl/wb_pkg.sv
`include "wb_config.svh"

package wb_pkg;

    typedef struct packed {
        logic [28:0] unused;
        logic [2:0]  idx;       // register or segment number
    } wb_reg_sel_t;

    // same word is a memory address or a register/segment index
    typedef union packed {
        logic [31:0] mem_addr;
        wb_reg_sel_t regs;
    } wb_dest_u;

    typedef struct packed {
        logic [63:0] data;
        wb_dest_u    dest;
        logic        is_reg;
        logic        is_seg;
        logic        is_mem;
        logic        wb;
    } wb_slot_t;

    typedef struct packed {
        logic       far_load;     // far jmp, far call, far ret
        logic       is_halt;
        logic       is_iretd;
        logic       is_jmp;
        logic       is_ret_far;
        logic [3:0] mem_size_ovr; // one-hot
        logic [1:0] op_size;
    } wb_uop_t;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        correct;
        logic [31:0] fip;
        logic [31:0] fip_p1;
        logic [7:0]  bp_alias;
    } wb_branch_t;

    typedef struct packed {
        logic       val;
        logic [3:0] ie_type;
    } wb_event_t;

    typedef struct packed {
        logic [`WB_SLOTS-1:0] reg_ld;
        logic [`WB_SLOTS-1:0] seg_ld;
        logic [`WB_SLOTS-1:0] mem_sel;
    } wb_strobe_t;

endpackage

//--- rtl/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

`define WB_SLOTS 4

// bit positions in the one-hot exception type
`define WB_IE_SEG  0
`define WB_IE_PAGE 1
`define WB_IE_INTR 3

// odd fetch line forced on an exception
`define WB_FIP_ODD_RESET 16

`endif
